//--- test/biquad_testdata.txt
# T name | W addr data (hex) | R addr (hex) | G pulses global_update_i
# S in0 in1 in2 in3 exp0 exp1 exp2 exp3 (signed decimal, lane 0 is the oldest sample)
T passthru
S 100 -200 300 -400 100 -200 300 -400
S 32767 -32768 0 1 32767 -32768 0 1
T shadow_no_update
W 08 00002000
W 0C 0003C000
W 1C 00000123
W 00 00000000
R 04
R 00
S 1000 2000 -3000 4000 1000 2000 -3000 4000
T fir_commit
W 00 00000001
S 100 200 300 400 100 250 300 350
S -50 0 7 -9 -150 -425 57 -6
S 1000 -1000 3 5 988 -491 -1497 1006
T pole_commit
W 08 00000000
W 0C 00000000
W 10 00004000
W 14 0003C000
W 00 00000001
S 10 0 0 0 10 10 0 -10
S 0 5 0 0 -10 5 15 10
S 100 -100 0 1 95 -15 -110 -94
T saturation
W 10 00000000
W 14 00000000
W 04 00010000
W 00 00000001
S 10000 -10000 100 -100 32767 -32768 400 -400
S 8191 8192 -8192 -8193 32764 32767 -32768 -32768
T global_update
W 04 00008000
W 0C 00001000
S 1000 -1000 2000 -2000 4000 -4000 8000 -8000
G
S 400 -400 1000 3 800 -800 2100 -94
S 10 20 -30 40 270 40 -58 85

//--- files.f
+incdir+include
design/biquad_pkg.sv
design/flag_sync.sv
design/bus_ctrl.sv
design/coeff_bank.sv
design/zero_fir.sv
design/pole_iir.sv
design/biquad_filter_top.sv
test/tb_biquad.sv

//--- test/tb_biquad.sv
`timescale 1ns/1ps
`default_nettype none
`include "biquad_regs.svh"

module tb_biquad;

   import biquad_pkg::*;

   localparam int NSAMP     = 4;
   localparam int CLK_HALF  = 2;
   localparam int WB_HALF   = 5;
   localparam int DRIVE_DLY = 1;
   localparam int ACK_LIMIT = 30;
   // longest data file and worst case time per line
   localparam int MAX_LINES = 200;
   localparam int LINE_NS   = 100;

   logic                clk_i;
   logic                wb_clk_i;
   logic                rst_n_i;
   bus_req_t            wb_req_i;
   logic                wb_ack_o;
   logic [DAT_W-1:0]    wb_dat_o;
   logic                global_update_i;
   sample_t [NSAMP-1:0] dat_i;
   sample_t [NSAMP-1:0] dat_o;

   // expected vectors in flight, entry 1 is due at the next step
   sample_t [NSAMP-1:0] exp_pipe [2];
   logic [1:0]          exp_valid;

   int              errors;
   int              checks;
   int              tests;
   int              failed_tests;
   int              test_errors;
   logic            test_open;
   logic [8*32-1:0] test_name;

   biquad_filter_top #(
      .NSAMP (NSAMP)
   ) uut (
      .wb_clk_i        (wb_clk_i),
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .wb_req_i        (wb_req_i),
      .wb_ack_o        (wb_ack_o),
      .wb_dat_o        (wb_dat_o),
      .global_update_i (global_update_i),
      .dat_i           (dat_i),
      .dat_o           (dat_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #CLK_HALF clk_i = ~clk_i;
   end

   initial begin
      wb_clk_i = 1'b0;
      forever #WB_HALF wb_clk_i = ~wb_clk_i;
   end

   task automatic check_val(input string name, input logic signed [63:0] expected,
                            input logic signed [63:0] actual);
      checks++;
      if (expected !== actual) begin
         errors++;
         $display("[FAIL] t=%0t %s expected %0d got %0d", $time, name, expected, actual);
      end
   endtask

   // one clk_i cycle: check the vector due now, then drive the next one
   task automatic step(input sample_t [NSAMP-1:0] in_vec,
                       input sample_t [NSAMP-1:0] exp_vec, input logic exp_en);
      @(posedge clk_i);
      #DRIVE_DLY;
      if (exp_valid[1]) begin
         for (int k = 0; k < NSAMP; k++) begin
            check_val($sformatf("dat_o[%0d]", k), exp_pipe[1][k], dat_o[k]);
         end
      end
      exp_pipe[1]  = exp_pipe[0];
      exp_valid[1] = exp_valid[0];
      exp_pipe[0]  = exp_vec;
      exp_valid[0] = exp_en;
      dat_i        = in_vec;
   endtask

   // drains the pipeline and leaves zeros on the input
   task automatic flush();
      repeat (2) step('0, '0, 1'b0);
   endtask

   task automatic bus_access(input logic we, input logic [ADR_W-1:0] adr,
                             input logic [DAT_W-1:0] dat);
      int   waited;
      logic seen;
      waited = 0;
      seen   = 1'b0;
      @(posedge wb_clk_i);
      #DRIVE_DLY;
      wb_req_i.cyc = 1'b1;
      wb_req_i.stb = 1'b1;
      wb_req_i.we  = we;
      wb_req_i.adr = adr;
      wb_req_i.dat = dat;
      while (!seen && waited < ACK_LIMIT) begin
         @(posedge wb_clk_i);
         #DRIVE_DLY;
         waited++;
         seen = wb_ack_o;
      end
      wb_req_i.stb = 1'b0;
      wb_req_i.we  = 1'b0;
      if (!seen) begin
         errors++;
         $display("no acknowledge within %0d bus cycles for the %s at address 0x%02h",
                  ACK_LIMIT, we ? "write" : "read", adr);
      end else if (!we) begin
         check_val("wb_dat_o", 0, wb_dat_o);
         check_val("read ack cycles", 1, waited);
      end
      // cyc stays up through the ack cycle
      @(posedge wb_clk_i);
      #DRIVE_DLY;
      wb_req_i.cyc = 1'b0;
      // a second ack would mean the request was taken twice
      repeat (2) begin
         check_val("wb_ack_o", 0, wb_ack_o);
         @(posedge wb_clk_i);
         #DRIVE_DLY;
      end
   endtask

   task automatic global_pulse();
      @(posedge clk_i);
      #DRIVE_DLY;
      global_update_i = 1'b1;
      @(posedge clk_i);
      #DRIVE_DLY;
      global_update_i = 1'b0;
      // registered update, then the copy into the active set
      repeat (3) step('0, '0, 1'b0);
   endtask

   task automatic close_test();
      int n;
      if (test_open) begin
         n = errors - test_errors;
         tests++;
         if (n == 0) begin
            $display("test %0s: ok", test_name);
         end else begin
            failed_tests++;
            $display("test %0s: %0d errors", test_name, n);
         end
      end
      test_open = 1'b0;
   endtask

   task automatic open_test(input logic [8*32-1:0] name);
      close_test();
      test_name   = name;
      test_open   = 1'b1;
      test_errors = errors;
   endtask

   task automatic run_file(input int fd);
      logic [8*32-1:0]     tok;
      logic [8*32-1:0]     name;
      logic [8*128-1:0]    rest;
      logic [DAT_W-1:0]    adr;
      logic [DAT_W-1:0]    dat;
      int                  in_v [NSAMP];
      int                  exp_v [NSAMP];
      sample_t [NSAMP-1:0] in_vec;
      sample_t [NSAMP-1:0] exp_vec;
      int                  code;
      while ($fscanf(fd, "%s", tok) == 1) begin
         if (tok == "#") begin
            code = $fgets(rest, fd);
         end else if (tok == "S") begin
            code = $fscanf(fd, "%d %d %d %d %d %d %d %d", in_v[0], in_v[1], in_v[2],
                           in_v[3], exp_v[0], exp_v[1], exp_v[2], exp_v[3]);
            if (code != 2 * NSAMP) begin
               errors++;
               $display("sample line in test data has %0d values instead of 8", code);
            end
            for (int k = 0; k < NSAMP; k++) begin
               in_vec[k]  = sample_t'(in_v[k]);
               exp_vec[k] = sample_t'(exp_v[k]);
            end
            step(in_vec, exp_vec, 1'b1);
         end else begin
            flush();
            if (tok == "T") begin
               code = $fscanf(fd, "%s", name);
               open_test(name);
            end else if (tok == "W") begin
               code = $fscanf(fd, "%h %h", adr, dat);
               bus_access(1'b1, adr[ADR_W-1:0], dat);
            end else if (tok == "R") begin
               code = $fscanf(fd, "%h", adr);
               bus_access(1'b0, adr[ADR_W-1:0], '0);
            end else if (tok == "G") begin
               global_pulse();
            end else begin
               errors++;
               $display("unknown command %0s in test data", tok);
               code = $fgets(rest, fd);
            end
         end
      end
      flush();
      close_test();
   endtask

   initial begin
      #(MAX_LINES * LINE_NS);
      $display("watchdog: run still busy after %0d ns", MAX_LINES * LINE_NS);
      $display("Something failed");
      $finish;
   end

   initial begin
      int fd;
      wb_req_i        = '0;
      global_update_i = 1'b0;
      dat_i           = '0;
      exp_pipe[0]     = '0;
      exp_pipe[1]     = '0;
      exp_valid       = '0;
      errors          = 0;
      checks          = 0;
      tests           = 0;
      failed_tests    = 0;
      test_errors     = 0;
      test_open       = 1'b0;
      test_name       = '0;
      rst_n_i         = 1'b0;
      repeat (5) @(posedge clk_i);
      #DRIVE_DLY;
      rst_n_i = 1'b1;

      open_test("reset");
      for (int k = 0; k < NSAMP; k++) begin
         check_val($sformatf("dat_o[%0d]", k), 0, dat_o[k]);
      end
      check_val("wb_ack_o", 0, wb_ack_o);
      bus_access(1'b0, `REG_CTRL, '0);
      close_test();

      fd = $fopen("test/biquad_testdata.txt", "r");
      if (fd == 0) begin
         errors++;
         $display("cannot open test/biquad_testdata.txt");
      end else begin
         run_file(fd);
         $fclose(fd);
      end

      $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
               tests, failed_tests, checks, errors);
      if (errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- design/biquad_filter_top.sv
`timescale 1ns/1ps
`default_nettype none

module biquad_filter_top #(
   parameter int NSAMP = 4
) (
   input  logic                            wb_clk_i,
   input  logic                            clk_i,
   input  logic                            rst_n_i,
   input  biquad_pkg::bus_req_t            wb_req_i,
   output logic                            wb_ack_o,
   output logic [biquad_pkg::DAT_W-1:0]    wb_dat_o,
   input  logic                            global_update_i,
   input  biquad_pkg::sample_t [NSAMP-1:0] dat_i,
   output biquad_pkg::sample_t [NSAMP-1:0] dat_o
);

   import biquad_pkg::*;

   logic             coef_wr;
   coeff_sel_t       coef_sel;
   coef_t            coef_dat;
   logic             commit;
   coeff_set_t       active;
   acc_t [NSAMP-1:0] fir_out;

   // bus side, crosses each write into clk_i
   bus_ctrl u_bus_ctrl (
      .wb_clk_i   (wb_clk_i),
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .wb_req_i   (wb_req_i),
      .wb_ack_o   (wb_ack_o),
      .wb_dat_o   (wb_dat_o),
      .coef_wr_o  (coef_wr),
      .coef_sel_o (coef_sel),
      .coef_dat_o (coef_dat),
      .commit_o   (commit)
   );

   coeff_bank u_coeff_bank (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .coef_wr_i       (coef_wr),
      .coef_sel_i      (coef_sel),
      .coef_dat_i      (coef_dat),
      .commit_i        (commit),
      .global_update_i (global_update_i),
      .active_o        (active)
   );

   zero_fir #(
      .NSAMP (NSAMP)
   ) u_zero_fir (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .dat_i   (dat_i),
      .coef_i  (active),
      .dat_o   (fir_out)
   );

   pole_iir #(
      .NSAMP (NSAMP)
   ) u_pole_iir (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .dat_i   (fir_out),
      .coef_i  (active),
      .dat_o   (dat_o)
   );

endmodule

`default_nettype wire

//--- design/pole_iir.sv
`timescale 1ns/1ps
`default_nettype none

module pole_iir #(
   parameter int NSAMP = 4
) (
   input  logic                            clk_i,
   input  logic                            rst_n_i,
   input  biquad_pkg::acc_t [NSAMP-1:0]    dat_i,
   input  biquad_pkg::coeff_set_t          coef_i,
   output biquad_pkg::sample_t [NSAMP-1:0] dat_o
);

   import biquad_pkg::*;

   localparam acc_t SAT_MAX = (acc_t'(1) <<< (SAMPLE_W-1)) - acc_t'(1);
   localparam acc_t SAT_MIN = -(acc_t'(1) <<< (SAMPLE_W-1));

   // y[-1] and y[-2] of the next vector, full width
   acc_t             y1_q;
   acc_t             y2_q;
   // y of lane k at index k+2, state below it
   acc_t [NSAMP+1:0] y_ext;

   function automatic sample_t saturate(input acc_t val);
      if (val > SAT_MAX) begin
         return sample_t'(SAT_MAX);
      end else if (val < SAT_MIN) begin
         return sample_t'(SAT_MIN);
      end
      return sample_t'(val);
   endfunction

   // recursion ripples through the lanes within one clock
   always_comb begin
      logic signed [ACC_W+COEF_W:0] fb;
      y_ext[1:0] = {y1_q, y2_q};
      for (int k = 0; k < NSAMP; k++) begin
         fb = coef_i.a1 * y_ext[k+1] + coef_i.a2 * y_ext[k];
         y_ext[k+2] = dat_i[k] + acc_t'(fb >>> COEF_FRAC);
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         y1_q  <= '0;
         y2_q  <= '0;
         dat_o <= '0;
      end else begin
         // state is not clipped, only the output is
         y1_q <= y_ext[NSAMP+1];
         y2_q <= y_ext[NSAMP];
         for (int k = 0; k < NSAMP; k++) begin
            dat_o[k] <= saturate(y_ext[k+2]);
         end
      end
   end

endmodule

`default_nettype wire

//--- design/zero_fir.sv
`timescale 1ns/1ps
`default_nettype none

module zero_fir #(
   parameter int NSAMP = 4
) (
   input  logic                            clk_i,
   input  logic                            rst_n_i,
   input  biquad_pkg::sample_t [NSAMP-1:0] dat_i,
   input  biquad_pkg::coeff_set_t          coef_i,
   output biquad_pkg::acc_t [NSAMP-1:0]    dat_o
);

   import biquad_pkg::*;

   // last two samples of the previous vector, older one in element 0
   sample_t [1:0]       hist_q;
   // lane k of the current vector sits at index k+2
   sample_t [NSAMP+1:0] x_ext;
   acc_t [NSAMP-1:0]    v;

   assign x_ext = {dat_i, hist_q};

   // lane 0 is the oldest sample of a vector
   always_comb begin
      acc_t sum;
      for (int k = 0; k < NSAMP; k++) begin
         sum = acc_t'(coef_i.b0) * acc_t'(x_ext[k+2])
             + acc_t'(coef_i.b1) * acc_t'(x_ext[k+1])
             + acc_t'(coef_i.b2) * acc_t'(x_ext[k]);
         // back to sample scale, extra headroom kept for the pole stage
         v[k] = sum >>> COEF_FRAC;
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         hist_q <= '0;
         dat_o  <= '0;
      end else begin
         hist_q <= dat_i[NSAMP-1 -: 2];
         dat_o  <= v;
      end
   end

endmodule

`default_nettype wire

//--- design/coeff_bank.sv
`timescale 1ns/1ps
`default_nettype none

module coeff_bank (
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   input  logic                   coef_wr_i,
   input  biquad_pkg::coeff_sel_t coef_sel_i,
   input  biquad_pkg::coef_t      coef_dat_i,
   input  logic                   commit_i,
   input  logic                   global_update_i,
   output biquad_pkg::coeff_set_t active_o
);

   import biquad_pkg::*;

   // unity gain pass-through
   localparam coeff_set_t RESET_SET = '{
      b0: COEF_ONE,
      b1: '0,
      b2: '0,
      a1: '0,
      a2: '0
   };

   coeff_set_t shadow_q;
   logic       update_q;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         shadow_q <= RESET_SET;
         active_o <= RESET_SET;
         update_q <= 1'b0;
      end else begin
         update_q <= global_update_i;
         if (coef_wr_i) begin
            case (coef_sel_i)
               COEF_B0: shadow_q.b0 <= coef_dat_i;
               COEF_B1: shadow_q.b1 <= coef_dat_i;
               COEF_B2: shadow_q.b2 <= coef_dat_i;
               COEF_A1: shadow_q.a1 <= coef_dat_i;
               COEF_A2: shadow_q.a2 <= coef_dat_i;
               default: ;
            endcase
         end
         // all five change on the same edge
         if (commit_i || update_q) begin
            active_o <= shadow_q;
         end
      end
   end

endmodule

`default_nettype wire

//--- design/bus_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "biquad_regs.svh"

module bus_ctrl (
   input  logic                         wb_clk_i,
   input  logic                         clk_i,
   input  logic                         rst_n_i,
   input  biquad_pkg::bus_req_t         wb_req_i,
   output logic                         wb_ack_o,
   output logic [biquad_pkg::DAT_W-1:0] wb_dat_o,
   output logic                         coef_wr_o,
   output biquad_pkg::coeff_sel_t       coef_sel_o,
   output biquad_pkg::coef_t            coef_dat_o,
   output logic                         commit_o
);

   import biquad_pkg::*;

   bus_ctrl_state_t state_q;
   logic            req_valid;
   logic            wr_start;
   logic            rd_ack_q;
   logic            wr_ack;
   logic            wr_clk;
   logic            ack_wb;
   coef_t           hold_dat_q;
   coeff_sel_t      hold_sel_q;
   logic            hold_upd_q;

   function automatic coeff_sel_t decode_sel(input logic [ADR_W-1:0] adr);
      case (adr)
         `REG_B0: return COEF_B0;
         `REG_B1: return COEF_B1;
         `REG_B2: return COEF_B2;
         `REG_A1: return COEF_A1;
         `REG_A2: return COEF_A2;
         default: return COEF_NONE;
      endcase
   endfunction

   assign req_valid = wb_req_i.cyc && wb_req_i.stb;
   // only the first cycle of a write starts a transfer
   assign wr_start  = (state_q == BUS_IDLE) && req_valid && wb_req_i.we;

   always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q  <= BUS_IDLE;
         rd_ack_q <= 1'b0;
      end else begin
         // reads have no readback, ack once and let the master drop stb
         rd_ack_q <= (state_q == BUS_IDLE) && req_valid && !wb_req_i.we && !rd_ack_q;
         case (state_q)
            BUS_IDLE: begin
               if (wr_start) begin
                  state_q <= BUS_WAIT_ACK;
               end
            end
            BUS_WAIT_ACK: begin
               if (ack_wb) begin
                  state_q <= BUS_IDLE;
               end
            end
            default: begin
               state_q <= BUS_IDLE;
            end
         endcase
      end
   end

   // stays put until the ack, so clk_i may sample it on arrival
   always_ff @(posedge wb_clk_i) begin
      if (wr_start) begin
         hold_dat_q <= coef_t'(wb_req_i.dat[COEF_W-1:0]);
         hold_sel_q <= decode_sel(wb_req_i.adr);
         hold_upd_q <= (wb_req_i.adr == `REG_CTRL) && wb_req_i.dat[`CTRL_UPDATE_BIT];
      end
   end

   flag_sync u_wr_sync (
      .clk_a_i   (wb_clk_i),
      .clk_b_i   (clk_i),
      .rst_n_i   (rst_n_i),
      .pulse_a_i (wr_start),
      .pulse_b_o (wr_clk)
   );

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         coef_wr_o <= 1'b0;
         commit_o  <= 1'b0;
      end else begin
         coef_wr_o <= wr_clk && (hold_sel_q != COEF_NONE);
         commit_o  <= wr_clk && hold_upd_q;
      end
   end

   always_ff @(posedge clk_i) begin
      if (wr_clk) begin
         coef_sel_o <= hold_sel_q;
         coef_dat_o <= hold_dat_q;
      end
   end

   // arrival pulse goes straight back as the write ack
   flag_sync u_ack_sync (
      .clk_a_i   (clk_i),
      .clk_b_i   (wb_clk_i),
      .rst_n_i   (rst_n_i),
      .pulse_a_i (wr_clk),
      .pulse_b_o (ack_wb)
   );

   assign wr_ack   = (state_q == BUS_WAIT_ACK) && ack_wb;
   assign wb_ack_o = rd_ack_q || wr_ack;
   assign wb_dat_o = '0;

   // the master must keep cyc up through the whole clock crossing
   a_ack_within_cycle : assert property (
      @(posedge wb_clk_i) disable iff (!rst_n_i) wb_ack_o |-> wb_req_i.cyc);

endmodule

`default_nettype wire

//--- design/flag_sync.sv
`timescale 1ns/1ps
`default_nettype none

module flag_sync (
   input  logic clk_a_i,
   input  logic clk_b_i,
   input  logic rst_n_i,
   input  logic pulse_a_i,
   output logic pulse_b_o
);

   logic       toggle_a_q;
   logic [2:0] sync_b_q;

   always_ff @(posedge clk_a_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         toggle_a_q <= 1'b0;
      end else if (pulse_a_i) begin
         toggle_a_q <= ~toggle_a_q;
      end
   end

   // first two stages settle the level, third keeps the previous one
   always_ff @(posedge clk_b_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         sync_b_q <= '0;
      end else begin
         sync_b_q <= {sync_b_q[1:0], toggle_a_q};
      end
   end

   // any change of the toggle is one event
   assign pulse_b_o = sync_b_q[2] ^ sync_b_q[1];

   // a held input would flip the toggle twice and the event gets lost
   a_single_cycle_pulse : assert property (
      @(posedge clk_a_i) disable iff (!rst_n_i) pulse_a_i |=> !pulse_a_i);

endmodule

`default_nettype wire

//--- design/biquad_pkg.sv
`default_nettype none

package biquad_pkg;

   localparam int SAMPLE_W = 16;
   localparam int COEF_W   = 18;
   localparam int ACC_W    = 40;
   localparam int ADR_W    = 5;
   localparam int DAT_W    = 32;

   typedef logic signed [SAMPLE_W-1:0] sample_t;
   // Q3.14
   typedef logic signed [COEF_W-1:0]   coef_t;
   typedef logic signed [ACC_W-1:0]    acc_t;

   // products are shifted right by this amount
   localparam int    COEF_FRAC = 14;
   localparam coef_t COEF_ONE  = coef_t'(16384);

   typedef enum logic [2:0] {
      COEF_B0,
      COEF_B1,
      COEF_B2,
      COEF_A1,
      COEF_A2,
      COEF_NONE
   } coeff_sel_t;

   typedef struct packed {
      coef_t b0;
      coef_t b1;
      coef_t b2;
      coef_t a1;
      coef_t a2;
   } coeff_set_t;

   typedef struct packed {
      logic             cyc;
      logic             stb;
      logic             we;
      // byte address of a 32-bit register
      logic [ADR_W-1:0] adr;
      logic [DAT_W-1:0] dat;
   } bus_req_t;

   typedef enum logic {
      BUS_IDLE,
      BUS_WAIT_ACK
   } bus_ctrl_state_t;

endpackage

`default_nettype wire

//--- include/biquad_regs.svh
`ifndef BIQUAD_REGS_SVH
`define BIQUAD_REGS_SVH

// control register, bit 0 copies all shadows into the active set
`define REG_CTRL 5'h00
`define CTRL_UPDATE_BIT 0

// shadow coefficient registers, Q3.14 in bits 17:0
`define REG_B0 5'h04
`define REG_B1 5'h08
`define REG_B2 5'h0C
`define REG_A1 5'h10
`define REG_A2 5'h14

`endif
